// File: verilog/fftConfigPkg.sv
`default_nettype none

package fftConfigPkg;

    localparam int PointCount  = 16;
    localparam int StageCount  = 4;    // log2 of PointCount
    localparam int SampleWidth = 10;
    localparam int TwiddleFrac = 9;    // Twiddles scaled by 511
    localparam int AddrWidth   = 5;    // Real and imaginary halves
    localparam int JobDepth    = 4;

    // W(k) = cos(2*pi*k/N) + j*sin(2*pi*k/N), k = 0..N/2-1
    localparam logic signed [SampleWidth-1:0] TwiddleRe [0:PointCount/2-1] = '{
        10'sd511, 10'sd472, 10'sd361, 10'sd196,
        10'sd0, -10'sd196, -10'sd361, -10'sd472
    };

    localparam logic signed [SampleWidth-1:0] TwiddleIm [0:PointCount/2-1] = '{
        10'sd0, 10'sd196, 10'sd361, 10'sd472,
        10'sd511, 10'sd472, 10'sd361, 10'sd196
    };

endpackage

`default_nettype wire

// File: verilog/fftTypesPkg.sv
`default_nettype none

package fftTypesPkg;

    import fftConfigPkg::*;

    typedef logic signed [SampleWidth-1:0] sample_t;
    typedef logic [AddrWidth-1:0] memAddr_t;
    typedef logic [StageCount-1:0] pointIdx_t;
    typedef logic [StageCount-2:0] twiddleIdx_t;
    typedef logic signed [2*SampleWidth-2:0] product_t;

    // Top index, bottom index, twiddle index, last flag
    localparam int JobWidth = 2 * StageCount + (StageCount - 1) + 1;
    typedef logic [JobWidth-1:0] job_t;

    typedef enum logic [1:0] {
        SeqIdle,
        SeqStage,
        SeqGroup,
        SeqWing
    } seqState_t;

    typedef enum logic [4:0] {
        UnitIdle,
        UnitWaitTopRe, UnitTakeTopRe,
        UnitWaitTopIm, UnitTakeTopIm,
        UnitWaitBotRe, UnitTakeBotRe,
        UnitWaitBotIm, UnitTakeBotIm,
        UnitMult, UnitShift, UnitSum, UnitHalf,
        UnitWriteTopRe, UnitWriteTopIm,
        UnitWriteBotRe, UnitWriteBotIm
    } unitState_t;

endpackage

`default_nettype wire

// File: verilog/butterflySequencer.sv
`timescale 1ns/1ns
`default_nettype none

module butterflySequencer
    import fftConfigPkg::*, fftTypesPkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic doFft,
    input  logic jobFull,
    output logic jobPush,
    output job_t job
);

    seqState_t   state;
    pointIdx_t   stageCnt;
    pointIdx_t   groups;      // Butterfly groups in this stage
    pointIdx_t   wings;       // Wings per group, also the top/bottom distance
    pointIdx_t   groupCnt;
    pointIdx_t   wingCnt;
    pointIdx_t   groupBase;
    pointIdx_t   top;
    twiddleIdx_t twIdx;
    twiddleIdx_t twStep;
    logic        lastJob;

    // Final wing of the single group in the final stage
    assign lastJob = (stageCnt == pointIdx_t'(StageCount)) && (groupCnt == groups)
        && (wingCnt == wings - 1'b1);

    assign jobPush = (state == SeqWing) && (wingCnt != wings) && !jobFull;
    assign job = {top, top + wings, twIdx, lastJob};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= SeqIdle;
        end
        else
        begin
            case (state)
                SeqIdle:
                begin
                    if (doFft)
                    begin
                        stageCnt <= '0;
                        state <= SeqStage;
                    end
                end
                SeqStage:
                begin
                    if (stageCnt == pointIdx_t'(StageCount))
                    begin
                        state <= SeqIdle;
                    end
                    else
                    begin
                        if (stageCnt == '0)
                        begin
                            groups <= pointIdx_t'(PointCount / 2);
                            wings <= pointIdx_t'(1);
                        end
                        else
                        begin
                            groups <= groups >> 1;
                            wings <= wings << 1;
                        end
                        twStep <= twiddleIdx_t'((PointCount / 2) >> stageCnt); // N/(2*wings)
                        groupBase <= '0;
                        groupCnt <= '0;
                        stageCnt <= stageCnt + 1'b1;
                        state <= SeqGroup;
                    end
                end
                SeqGroup:
                begin
                    if (groupCnt == groups)
                    begin
                        state <= SeqStage;
                    end
                    else
                    begin
                        top <= groupBase;
                        groupBase <= groupBase + (wings << 1);
                        twIdx <= '0;
                        wingCnt <= '0;
                        groupCnt <= groupCnt + 1'b1;
                        state <= SeqWing;
                    end
                end
                SeqWing:
                begin
                    if (wingCnt == wings)
                    begin
                        state <= SeqGroup;
                    end
                    else if (!jobFull) // Hold while FIFO is full
                    begin
                        top <= top + 1'b1;
                        twIdx <= twIdx + twStep;
                        wingCnt <= wingCnt + 1'b1;
                    end
                end
                default:
                    state <= SeqIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/butterflyJobFifo.sv
`timescale 1ns/1ns
`default_nettype none

module butterflyJobFifo
    import fftConfigPkg::*, fftTypesPkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic jobPush,
    input  job_t job,
    input  logic jobPop,
    output job_t jobHead,
    output logic jobFull,
    output logic jobEmpty
);

    job_t mem [0:JobDepth-1];

    logic [$clog2(JobDepth)-1:0]   wrPtr;
    logic [$clog2(JobDepth)-1:0]   rdPtr;
    logic [$clog2(JobDepth+1)-1:0] count;
    logic                          doPush;
    logic                          doPop;

    assign jobFull  = (count == JobDepth);
    assign jobEmpty = (count == 0);
    assign doPush   = jobPush && !jobFull;
    assign doPop    = jobPop && !jobEmpty;
    assign jobHead  = mem[rdPtr];

    always_ff @(posedge clk)
    begin
        if (doPush)
        begin
            mem[wrPtr] <= job;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
            begin
                wrPtr <= (wrPtr == JobDepth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doPop)
            begin
                rdPtr <= (rdPtr == JobDepth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop)
            begin
                count <= count + 1'b1;
            end
            else if (doPop && !doPush)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/butterflyUnit.sv
`timescale 1ns/1ns
`default_nettype none

module butterflyUnit
    import fftConfigPkg::*, fftTypesPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  job_t     jobHead,
    input  logic     jobEmpty,
    output logic     jobPop,
    output memAddr_t addr,
    output logic     writeEnable,
    output sample_t  dataOut,
    input  sample_t  dataIn,
    output logic     fftDone
);

    unitState_t  state;
    pointIdx_t   headTop;
    pointIdx_t   headBottom;
    twiddleIdx_t headTw;
    logic        headLast;
    pointIdx_t   top;
    pointIdx_t   bottom;
    logic        last;
    sample_t     twRe;
    sample_t     twIm;
    sample_t     aRe;         // Top wing, later top result
    sample_t     aIm;
    sample_t     bRe;         // Bottom wing, later W*B, then bottom result
    sample_t     bIm;
    product_t    prodRe;
    product_t    prodIm;

    assign {headTop, headBottom, headTw, headLast} = jobHead;
    assign jobPop = (state == UnitIdle) && !jobEmpty;

    function automatic memAddr_t reAddr(input pointIdx_t idx);
        reAddr = memAddr_t'(idx);
    endfunction

    function automatic memAddr_t imAddr(input pointIdx_t idx);
        imAddr = memAddr_t'(idx) + memAddr_t'(PointCount);
    endfunction

    // Signed divide truncates toward zero
    function automatic sample_t halve(input sample_t v);
        halve = v / 2;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= UnitIdle;
            writeEnable <= 1'b0;
            fftDone <= 1'b0;
        end
        else
        begin
            fftDone <= 1'b0;
            case (state)
                UnitIdle:
                begin
                    if (!jobEmpty)
                    begin
                        top <= headTop;
                        bottom <= headBottom;
                        last <= headLast;
                        twRe <= TwiddleRe[headTw];
                        twIm <= TwiddleIm[headTw];
                        addr <= reAddr(headTop);
                        state <= UnitWaitTopRe;
                    end
                end
                UnitWaitTopRe:
                    state <= UnitTakeTopRe;
                UnitTakeTopRe:
                begin
                    aRe <= dataIn;
                    addr <= imAddr(top);
                    state <= UnitWaitTopIm;
                end
                UnitWaitTopIm:
                    state <= UnitTakeTopIm;
                UnitTakeTopIm:
                begin
                    aIm <= dataIn;
                    addr <= reAddr(bottom);
                    state <= UnitWaitBotRe;
                end
                UnitWaitBotRe:
                    state <= UnitTakeBotRe;
                UnitTakeBotRe:
                begin
                    bRe <= dataIn;
                    addr <= imAddr(bottom);
                    state <= UnitWaitBotIm;
                end
                UnitWaitBotIm:
                    state <= UnitTakeBotIm;
                UnitTakeBotIm:
                begin
                    bIm <= dataIn;
                    state <= UnitMult;
                end
                UnitMult:
                begin
                    prodRe <= bRe * twRe - bIm * twIm;
                    prodIm <= bRe * twIm + bIm * twRe;
                    state <= UnitShift;
                end
                UnitShift:
                begin
                    bRe <= sample_t'(prodRe >>> TwiddleFrac); // Back to Q0
                    bIm <= sample_t'(prodIm >>> TwiddleFrac);
                    state <= UnitSum;
                end
                UnitSum:
                begin
                    aRe <= aRe + bRe;
                    aIm <= aIm + bIm;
                    bRe <= bRe - aRe;  // WB - A
                    bIm <= bIm - aIm;
                    state <= UnitHalf;
                end
                UnitHalf:
                begin
                    aRe <= halve(aRe);
                    aIm <= halve(aIm);
                    bRe <= halve(bRe);
                    bIm <= halve(bIm);
                    writeEnable <= 1'b1;
                    addr <= reAddr(top);
                    dataOut <= halve(aRe); // First word goes out with the halving
                    state <= UnitWriteTopRe;
                end
                UnitWriteTopRe:
                begin
                    addr <= imAddr(top);
                    dataOut <= aIm;
                    state <= UnitWriteTopIm;
                end
                UnitWriteTopIm:
                begin
                    addr <= reAddr(bottom);
                    dataOut <= bRe;
                    state <= UnitWriteBotRe;
                end
                UnitWriteBotRe:
                begin
                    addr <= imAddr(bottom);
                    dataOut <= bIm;
                    state <= UnitWriteBotIm;
                end
                UnitWriteBotIm:
                begin
                    writeEnable <= 1'b0;
                    fftDone <= last; // Lands after the final word is stored
                    state <= UnitIdle;
                end
                default:
                    state <= UnitIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/fftEngine.sv
`timescale 1ns/1ns
`default_nettype none

module fftEngine
    import fftTypesPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     doFft,
    output logic     fftDone,
    output memAddr_t addr,
    output logic     writeEnable,
    output sample_t  dataOut,
    input  sample_t  dataIn
);

    logic jobPush;
    logic jobPop;
    logic jobFull;
    logic jobEmpty;
    job_t job;
    job_t jobHead;

    butterflySequencer u_sequencer (
        .clk     (clk),
        .rst_n   (rst_n),
        .doFft   (doFft),
        .jobFull (jobFull),
        .jobPush (jobPush),
        .job     (job)
    );

    butterflyJobFifo u_jobFifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .jobPush  (jobPush),
        .job      (job),
        .jobPop   (jobPop),
        .jobHead  (jobHead),
        .jobFull  (jobFull),
        .jobEmpty (jobEmpty)
    );

    butterflyUnit u_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .jobHead     (jobHead),
        .jobEmpty    (jobEmpty),
        .jobPop      (jobPop),
        .addr        (addr),
        .writeEnable (writeEnable),
        .dataOut     (dataOut),
        .dataIn      (dataIn),
        .fftDone     (fftDone)
    );

endmodule

`default_nettype wire

// File: testbench/sampleMemory.sv
`timescale 1ns/1ns
`default_nettype none

module sampleMemory
    import fftConfigPkg::*, fftTypesPkg::*;
(
    input  logic     clk,
    input  memAddr_t addr,
    input  logic     writeEnable,
    input  sample_t  writeData,
    output sample_t  readData,
    input  logic     loadEnable,   // Testbench side port
    input  memAddr_t loadAddr,
    input  sample_t  loadData,
    input  memAddr_t peekAddr,
    output sample_t  peekData
);

    sample_t mem [0:2*PointCount-1];

    assign peekData = mem[peekAddr];

    always_ff @(posedge clk)
    begin
        if (loadEnable)
        begin
            mem[loadAddr] <= loadData;
        end
        else if (writeEnable)
        begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr]; // One cycle read latency
    end

endmodule

`default_nettype wire

// File: testbench/fftEngine_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module fftEngine_assertions
    import fftConfigPkg::*, fftTypesPkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     fftDone,
    input logic     writeEnable,
    input memAddr_t addr
);

    noWriteAfterReset: assert property (@(posedge clk) $rose(rst_n) |=> !writeEnable)
        else $error("writeEnable rose right after reset release");

    donePulse: assert property (@(posedge clk) disable iff (!rst_n) fftDone |=> !fftDone)
        else $error("fftDone held longer than one cycle");

    addrInRange: assert property (@(posedge clk) disable iff (!rst_n)
        writeEnable |-> (!$isunknown(addr) && int'(addr) < 2 * PointCount))
        else $error("write address unknown or out of range");

endmodule

bind fftEngine fftEngine_assertions u_assertions (.*);

`default_nettype wire

// File: testbench/fftEngineTb.sv
`timescale 1ns/1ns
`default_nettype none

module fftEngineTb
    import fftConfigPkg::*, fftTypesPkg::*;
;

    localparam int TransformBound = 600;  // 32 butterflies of 17 cycles plus loop overhead
    localparam int CycleLimit = 4 * 2 * TransformBound;  // 4x the bound of two transforms
    localparam int WordCount = 2 * PointCount;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     doFft;
    logic     fftDone;
    memAddr_t addr;
    logic     writeEnable;
    sample_t  dataOut;
    sample_t  dataIn;
    logic     loadEnable;
    memAddr_t loadAddr;
    sample_t  loadData;
    memAddr_t peekAddr;
    sample_t  peekData;

    logic [SampleWidth-1:0] stim [0:3*WordCount-1]; // Input, first, second per address
    int cycles = 0;
    int doneCount = 0;
    int errors = 0;

    fftEngine u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .doFft       (doFft),
        .fftDone     (fftDone),
        .addr        (addr),
        .writeEnable (writeEnable),
        .dataOut     (dataOut),
        .dataIn      (dataIn)
    );

    sampleMemory u_mem (
        .clk         (clk),
        .addr        (addr),
        .writeEnable (writeEnable),
        .writeData   (dataOut),
        .readData    (dataIn),
        .loadEnable  (loadEnable),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .peekAddr    (peekAddr),
        .peekData    (peekData)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (rst_n && fftDone)
        begin
            doneCount <= doneCount + 1;
        end
        if (cycles >= CycleLimit)
        begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic loadMemory();
        for (int i = 0; i < WordCount; i++)
        begin
            @(negedge clk);
            loadEnable = 1'b1;
            loadAddr = memAddr_t'(i);
            loadData = sample_t'(stim[3*i]);
            assert (writeEnable === 1'b0) // Idle engine must not write
                else begin
                    errors++;
                    $display("ERROR at %0t: writeEnable got %b expected 0", $time, writeEnable);
                end
            assert (fftDone === 1'b0)
                else begin
                    errors++;
                    $display("ERROR at %0t: fftDone got %b expected 0", $time, fftDone);
                end
        end
        @(negedge clk);
        loadEnable = 1'b0;
    endtask

    // Starts one transform, optionally with a stray start pulse while busy
    task automatic runTransform(input bit strayPulse);
        int startCount;
        int waited;
        startCount = doneCount;
        waited = 0;
        @(negedge clk);
        doFft = 1'b1;
        while (doneCount == startCount)
        begin
            @(negedge clk);
            waited++;
            doFft = (strayPulse && waited == 20);
        end
        repeat (TransformBound) @(negedge clk); // Long enough for a second transform to end
        assert (doneCount == startCount + 1)
            else begin
                errors++;
                $display("Expected one fftDone pulse but saw %0d", doneCount - startCount);
            end
    endtask

    task automatic compareMemory(input int column);
        sample_t expected;
        for (int i = 0; i < WordCount; i++)
        begin
            peekAddr = memAddr_t'(i);
            #1;
            expected = sample_t'(stim[3*i+column]);
            assert (peekData === expected)
                else begin
                    errors++;
                    $display("ERROR at %0t: mem[%0d] got %h expected %h",
                        $time, i, peekData, expected);
                end
        end
    endtask

    initial
    begin
        rst_n = 1'b0;
        doFft = 1'b0;
        loadEnable = 1'b0;
        loadAddr = '0;
        loadData = '0;
        peekAddr = '0;
        $readmemh("testbench/fftEngine_stim.txt", stim);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        loadMemory();
        runTransform(1'b0);
        compareMemory(1);
        runTransform(1'b1);   // Second pass in place
        compareMemory(2);
        $display("Checks complete with %0d errors", errors);
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fftEngine.f
verilog/fftConfigPkg.sv
verilog/fftTypesPkg.sv
verilog/butterflySequencer.sv
verilog/butterflyJobFifo.sv
verilog/butterflyUnit.sv
verilog/fftEngine.sv
testbench/sampleMemory.sv
testbench/fftEngine_assertions.sv
testbench/fftEngineTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the FFT engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fftEngineTb \
    -Mdir obj_dir -f fftEngine.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/VfftEngineTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: testbench/fftEngine_stim.txt
// Columns: input word, after first transform, after second transform (10-bit hex)
// Addresses 0-15 are real parts, 16-31 imaginary parts
100 010 000
000 3F0 000
000 3F0 000
000 010 004
000 3F0 000
000 010 004
000 010 000
000 3F0 000
000 3F0 000
000 010 3FF
000 010 000
000 3F0 3FC
000 010 000
000 3F0 3FC
000 3F0 000
000 010 000
000 000 000
000 000 3FF
000 000 000
000 000 3FD
000 000 000
000 000 3F9
000 000 000
000 000 3FC
000 000 000
000 000 3FC
000 000 000
000 000 3FA
000 000 000
000 000 3FD
000 000 000
000 000 3FF
